// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int LEN        = 32;   // Data and instruction width
    localparam int NB_ADDR    = 5;    // Register index
    localparam int NB_FUNC    = 6;
    localparam int NB_OPCODE  = 6;
    localparam int NB_IMM     = 16;
    localparam int NB_ALUOP   = 2;
    localparam int NB_ALUCTL  = 4;
    localparam int NUM_REGS   = 32;
    localparam int DMEM_DEPTH = 64;   // Data memory words
    localparam int NB_DMEM    = $clog2(DMEM_DEPTH);

    // Control groups travelling down the pipe
    localparam int NB_CTRL_EX = 4;    // alu_src, alu_op, reg_dst
    localparam int NB_CTRL_M  = 3;    // branch, mem_read, mem_write
    localparam int NB_CTRL_WB = 2;    // reg_write, mem_to_reg

    localparam int EX_ALU_SRC    = 3;
    localparam int EX_ALU_OP_HI  = 2;
    localparam int EX_ALU_OP_LO  = 1;
    localparam int EX_REG_DST    = 0; // Set picks rt
    localparam int M_BRANCH      = 2;
    localparam int M_MEM_READ    = 1;
    localparam int M_MEM_WRITE   = 0;
    localparam int WB_REG_WRITE  = 1;
    localparam int WB_MEM_TO_REG = 0;

    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;

    localparam logic [NB_FUNC-1:0] FN_ADD = 6'h20;
    localparam logic [NB_FUNC-1:0] FN_SUB = 6'h22;
    localparam logic [NB_FUNC-1:0] FN_AND = 6'h24;
    localparam logic [NB_FUNC-1:0] FN_OR  = 6'h25;
    localparam logic [NB_FUNC-1:0] FN_SLT = 6'h2a;

    localparam logic [NB_ALUOP-1:0] ALUOP_ADD   = 2'b00;  // Address calculation
    localparam logic [NB_ALUOP-1:0] ALUOP_SUB   = 2'b01;  // beq compare
    localparam logic [NB_ALUOP-1:0] ALUOP_FUNCT = 2'b10;

    localparam logic [NB_ALUCTL-1:0] ALU_AND = 4'b0000;
    localparam logic [NB_ALUCTL-1:0] ALU_OR  = 4'b0001;
    localparam logic [NB_ALUCTL-1:0] ALU_ADD = 4'b0010;
    localparam logic [NB_ALUCTL-1:0] ALU_SUB = 4'b0110;
    localparam logic [NB_ALUCTL-1:0] ALU_SLT = 4'b0111;

    // Same word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_ADDR-1:0]   rs;
            logic [NB_ADDR-1:0]   rt;
            logic [NB_ADDR-1:0]   rd;
            logic [NB_ADDR-1:0]   shamt;
            logic [NB_FUNC-1:0]   funct;
        } r;
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_ADDR-1:0]   rs;
            logic [NB_ADDR-1:0]   rt;
            logic [NB_IMM-1:0]    imm;
        } i;
    } instr_t;

endpackage

// File: source/register_file.sv
module register_file (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic [cpu_pkg::NB_ADDR-1:0]  i_rs_addr,
    input  logic [cpu_pkg::NB_ADDR-1:0]  i_rt_addr,
    output logic [cpu_pkg::LEN-1:0]      o_rs_data,
    output logic [cpu_pkg::LEN-1:0]      o_rt_data,
    input  logic                         i_wr_en,
    input  logic [cpu_pkg::NB_ADDR-1:0]  i_wr_addr,
    input  logic [cpu_pkg::LEN-1:0]      i_wr_data
);

    logic [cpu_pkg::LEN-1:0] regs [cpu_pkg::NUM_REGS];

    // Writes held off while in reset, r0 never written
    always_ff @(posedge i_clk) begin
        if (i_rst && i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Bypass lets decode see the write-back of the same edge
    always_comb begin
        if (i_rs_addr == '0) begin
            o_rs_data = '0;
        end else if (i_wr_en && (i_wr_addr == i_rs_addr)) begin
            o_rs_data = i_wr_data;
        end else begin
            o_rs_data = regs[i_rs_addr];
        end
    end

    always_comb begin
        if (i_rt_addr == '0) begin
            o_rt_data = '0;
        end else if (i_wr_en && (i_wr_addr == i_rt_addr)) begin
            o_rt_data = i_wr_data;
        end else begin
            o_rt_data = regs[i_rt_addr];
        end
    end

endmodule

// File: source/decode_stage.sv
module decode_stage (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_instr_valid,
    input  logic [cpu_pkg::LEN-1:0]         i_instr,
    input  logic [cpu_pkg::LEN-1:0]         i_pc,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_rs_addr,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_rt_addr,
    input  logic [cpu_pkg::LEN-1:0]         i_rs_data,
    input  logic [cpu_pkg::LEN-1:0]         i_rt_data,
    output logic                            o_valid,
    output logic [cpu_pkg::LEN-1:0]         o_pc,
    output logic [cpu_pkg::LEN-1:0]         o_read_data_1,
    output logic [cpu_pkg::LEN-1:0]         o_read_data_2,
    output logic [cpu_pkg::LEN-1:0]         o_addr_ext,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_rt,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_rd,
    output logic [cpu_pkg::NB_CTRL_WB-1:0]  o_ctrl_wb_bus,
    output logic [cpu_pkg::NB_CTRL_M-1:0]   o_ctrl_mem_bus,
    output logic [cpu_pkg::NB_CTRL_EX-1:0]  o_ctrl_exc_bus
);

    cpu_pkg::instr_t                 instr;
    logic                            known;    // Opcode in the subset
    logic                            go;
    logic [cpu_pkg::NB_CTRL_EX-1:0]  ctrl_ex;
    logic [cpu_pkg::NB_CTRL_M-1:0]   ctrl_m;
    logic [cpu_pkg::NB_CTRL_WB-1:0]  ctrl_wb;

    assign instr     = i_instr;
    assign o_rs_addr = instr.r.rs;
    assign o_rt_addr = instr.r.rt;
    assign go        = i_instr_valid && known;

    always_comb begin
        known   = 1'b1;
        ctrl_ex = '0;
        ctrl_m  = '0;
        ctrl_wb = '0;
        case (instr.r.opcode)
            cpu_pkg::OP_RTYPE: begin
                ctrl_ex[cpu_pkg::EX_ALU_OP_HI:cpu_pkg::EX_ALU_OP_LO] = cpu_pkg::ALUOP_FUNCT;
                ctrl_wb[cpu_pkg::WB_REG_WRITE] = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LW: begin
                ctrl_ex[cpu_pkg::EX_ALU_SRC] = 1'b1;
                ctrl_ex[cpu_pkg::EX_REG_DST] = 1'b1;          // Writes rt
                ctrl_wb[cpu_pkg::WB_REG_WRITE] = 1'b1;
                if (instr.r.opcode == cpu_pkg::OP_LW) begin
                    ctrl_m[cpu_pkg::M_MEM_READ]     = 1'b1;
                    ctrl_wb[cpu_pkg::WB_MEM_TO_REG] = 1'b1;
                end
            end
            cpu_pkg::OP_SW: begin
                ctrl_ex[cpu_pkg::EX_ALU_SRC] = 1'b1;
                ctrl_m[cpu_pkg::M_MEM_WRITE] = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                ctrl_ex[cpu_pkg::EX_ALU_OP_HI:cpu_pkg::EX_ALU_OP_LO] = cpu_pkg::ALUOP_SUB;
                ctrl_m[cpu_pkg::M_BRANCH] = 1'b1;
            end
            default: known = 1'b0;                            // Treated as a bubble
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_valid        <= 1'b0;
            o_ctrl_wb_bus  <= '0;
            o_ctrl_mem_bus <= '0;
            o_ctrl_exc_bus <= '0;
        end else begin
            o_valid        <= go;
            o_ctrl_wb_bus  <= go ? ctrl_wb : '0;
            o_ctrl_mem_bus <= go ? ctrl_m  : '0;
            o_ctrl_exc_bus <= go ? ctrl_ex : '0;
        end
    end

    // Operands and fields
    always_ff @(posedge i_clk) begin
        o_pc          <= i_pc;
        o_read_data_1 <= i_rs_data;
        o_read_data_2 <= i_rt_data;
        o_addr_ext    <= {{(cpu_pkg::LEN-cpu_pkg::NB_IMM){instr.i.imm[cpu_pkg::NB_IMM-1]}},
                          instr.i.imm};
        o_rt          <= instr.r.rt;
        o_rd          <= instr.r.rd;
    end

endmodule

// File: source/alu_control.sv
module alu_control (
    input  logic [cpu_pkg::NB_FUNC-1:0]    i_funct,
    input  logic [cpu_pkg::NB_ALUOP-1:0]   i_alu_op,
    output logic [cpu_pkg::NB_ALUCTL-1:0]  o_alu_ctl
);

    always_comb begin
        case (i_alu_op)
            cpu_pkg::ALUOP_ADD: o_alu_ctl = cpu_pkg::ALU_ADD;    // lw, sw, addi
            cpu_pkg::ALUOP_SUB: o_alu_ctl = cpu_pkg::ALU_SUB;    // beq
            cpu_pkg::ALUOP_FUNCT: begin
                case (i_funct)
                    cpu_pkg::FN_ADD: o_alu_ctl = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: o_alu_ctl = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: o_alu_ctl = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  o_alu_ctl = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: o_alu_ctl = cpu_pkg::ALU_SLT;
                    default:         o_alu_ctl = cpu_pkg::ALU_ADD;
                endcase
            end
            default: o_alu_ctl = cpu_pkg::ALU_ADD;
        endcase
    end

endmodule

// File: source/alu.sv
module alu (
    input  logic [cpu_pkg::NB_ALUCTL-1:0]  i_alu_ctl,
    input  logic [cpu_pkg::LEN-1:0]        i_data_a,
    input  logic [cpu_pkg::LEN-1:0]        i_data_b,
    output logic [cpu_pkg::LEN-1:0]        o_alu_out,
    output logic                           o_zero
);

    logic less;

    assign less = $signed(i_data_a) < $signed(i_data_b);   // slt is signed

    always_comb begin
        case (i_alu_ctl)
            cpu_pkg::ALU_AND: o_alu_out = i_data_a & i_data_b;
            cpu_pkg::ALU_OR:  o_alu_out = i_data_a | i_data_b;
            cpu_pkg::ALU_ADD: o_alu_out = i_data_a + i_data_b;
            cpu_pkg::ALU_SUB: o_alu_out = i_data_a - i_data_b;
            cpu_pkg::ALU_SLT: o_alu_out = {{(cpu_pkg::LEN-1){1'b0}}, less};
            default:          o_alu_out = '0;
        endcase
    end

    assign o_zero = (o_alu_out == '0);

endmodule

// File: source/execute_stage.sv
module execute_stage (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_valid,
    input  logic [cpu_pkg::LEN-1:0]         i_pc,
    input  logic [cpu_pkg::LEN-1:0]         i_read_data_1,
    input  logic [cpu_pkg::LEN-1:0]         i_read_data_2,
    input  logic [cpu_pkg::LEN-1:0]         i_addr_ext,
    input  logic [cpu_pkg::NB_ADDR-1:0]     i_rt,
    input  logic [cpu_pkg::NB_ADDR-1:0]     i_rd,
    input  logic [cpu_pkg::NB_CTRL_WB-1:0]  i_ctrl_wb_bus,
    input  logic [cpu_pkg::NB_CTRL_M-1:0]   i_ctrl_mem_bus,
    input  logic [cpu_pkg::NB_CTRL_EX-1:0]  i_ctrl_exc_bus,
    output logic                            o_valid,
    output logic [cpu_pkg::LEN-1:0]         o_pc_branch,
    output logic [cpu_pkg::LEN-1:0]         o_alu_result,
    output logic [cpu_pkg::LEN-1:0]         o_write_data,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_write_register,
    output logic                            o_alu_zero,
    output logic [cpu_pkg::NB_CTRL_WB-1:0]  o_ctrl_wb_bus,
    output logic [cpu_pkg::NB_CTRL_M-1:0]   o_ctrl_mem_bus
);

    logic [cpu_pkg::NB_ALUCTL-1:0] alu_ctl;
    logic [cpu_pkg::LEN-1:0]       data_b;
    logic [cpu_pkg::LEN-1:0]       alu_out;
    logic                          zero;

    // Immediate as operand for addi, lw and sw
    assign data_b = i_ctrl_exc_bus[cpu_pkg::EX_ALU_SRC] ? i_addr_ext : i_read_data_2;

    alu_control u_alu_control (
        .i_funct   (i_addr_ext[cpu_pkg::NB_FUNC-1:0]),   // Low bits of the immediate
        .i_alu_op  (i_ctrl_exc_bus[cpu_pkg::EX_ALU_OP_HI:cpu_pkg::EX_ALU_OP_LO]),
        .o_alu_ctl (alu_ctl)
    );

    alu u_alu (
        .i_alu_ctl (alu_ctl),
        .i_data_a  (i_read_data_1),
        .i_data_b  (data_b),
        .o_alu_out (alu_out),
        .o_zero    (zero)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_valid        <= 1'b0;
            o_ctrl_wb_bus  <= '0;
            o_ctrl_mem_bus <= '0;
        end else begin
            o_valid        <= i_valid;
            o_ctrl_wb_bus  <= i_valid ? i_ctrl_wb_bus  : '0;
            o_ctrl_mem_bus <= i_valid ? i_ctrl_mem_bus : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc_branch      <= i_pc + (i_addr_ext << 2);   // Word offset
        o_alu_result     <= alu_out;
        o_write_data     <= i_read_data_2;              // Store data is always rt
        o_write_register <= i_ctrl_exc_bus[cpu_pkg::EX_REG_DST] ? i_rt : i_rd;
        o_alu_zero       <= zero;
    end

endmodule

// File: source/memory_stage.sv
module memory_stage (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_valid,
    input  logic [cpu_pkg::LEN-1:0]         i_pc_branch,
    input  logic [cpu_pkg::LEN-1:0]         i_alu_result,
    input  logic [cpu_pkg::LEN-1:0]         i_write_data,
    input  logic [cpu_pkg::NB_ADDR-1:0]     i_write_register,
    input  logic                            i_alu_zero,
    input  logic [cpu_pkg::NB_CTRL_WB-1:0]  i_ctrl_wb_bus,
    input  logic [cpu_pkg::NB_CTRL_M-1:0]   i_ctrl_mem_bus,
    output logic                            o_wb_valid,
    output logic [cpu_pkg::NB_ADDR-1:0]     o_wb_reg,
    output logic [cpu_pkg::LEN-1:0]         o_wb_data,
    output logic                            o_branch_taken,
    output logic [cpu_pkg::LEN-1:0]         o_branch_target
);

    logic [cpu_pkg::LEN-1:0]     dmem [cpu_pkg::DMEM_DEPTH];
    logic [cpu_pkg::NB_DMEM-1:0] word_addr;
    logic [cpu_pkg::LEN-1:0]     load_q;
    logic [cpu_pkg::LEN-1:0]     alu_q;
    logic                        mem_to_reg_q;

    assign word_addr = i_alu_result[cpu_pkg::NB_DMEM+1:2];   // Byte address to word index

    always_ff @(posedge i_clk) begin
        if (i_valid && i_ctrl_mem_bus[cpu_pkg::M_MEM_WRITE]) begin
            dmem[word_addr] <= i_write_data;
        end
        if (i_ctrl_mem_bus[cpu_pkg::M_MEM_READ]) begin
            load_q <= dmem[word_addr];                         // Synchronous read
        end
        alu_q           <= i_alu_result;
        mem_to_reg_q    <= i_ctrl_wb_bus[cpu_pkg::WB_MEM_TO_REG];
        o_wb_reg        <= i_write_register;
        o_branch_target <= i_pc_branch;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_wb_valid     <= 1'b0;
            o_branch_taken <= 1'b0;
        end else begin
            o_wb_valid     <= i_valid && i_ctrl_wb_bus[cpu_pkg::WB_REG_WRITE];
            o_branch_taken <= i_valid && i_ctrl_mem_bus[cpu_pkg::M_BRANCH] && i_alu_zero;
        end
    end

    // Load word or ALU result
    assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

// File: source/pipeline_top.sv
module pipeline_top (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_instr_valid,
    input  logic [cpu_pkg::LEN-1:0]      i_instr,
    input  logic [cpu_pkg::LEN-1:0]      i_pc,
    output logic                         o_wb_valid,
    output logic [cpu_pkg::NB_ADDR-1:0]  o_wb_reg,
    output logic [cpu_pkg::LEN-1:0]      o_wb_data,
    output logic                         o_branch_taken,
    output logic [cpu_pkg::LEN-1:0]      o_branch_target
);

    logic [cpu_pkg::NB_ADDR-1:0]     rs_addr, rt_addr;
    logic [cpu_pkg::LEN-1:0]         rs_data, rt_data;

    // Decode to execute
    logic                            de_valid;
    logic [cpu_pkg::LEN-1:0]         de_pc, de_rd1, de_rd2, de_ext;
    logic [cpu_pkg::NB_ADDR-1:0]     de_rt, de_rd;
    logic [cpu_pkg::NB_CTRL_WB-1:0]  de_wb;
    logic [cpu_pkg::NB_CTRL_M-1:0]   de_m;
    logic [cpu_pkg::NB_CTRL_EX-1:0]  de_ex;

    // Execute to memory
    logic                            em_valid, em_zero;
    logic [cpu_pkg::LEN-1:0]         em_target, em_result, em_wdata;
    logic [cpu_pkg::NB_ADDR-1:0]     em_wreg;
    logic [cpu_pkg::NB_CTRL_WB-1:0]  em_wb;
    logic [cpu_pkg::NB_CTRL_M-1:0]   em_m;

    register_file u_register_file (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_rs_addr (rs_addr), .i_rt_addr (rt_addr),
        .o_rs_data (rs_data), .o_rt_data (rt_data),
        .i_wr_en   (o_wb_valid),                   // Write-back straight from memory stage
        .i_wr_addr (o_wb_reg), .i_wr_data (o_wb_data)
    );

    decode_stage u_decode_stage (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_instr_valid (i_instr_valid), .i_instr (i_instr), .i_pc (i_pc),
        .o_rs_addr (rs_addr), .o_rt_addr (rt_addr),
        .i_rs_data (rs_data), .i_rt_data (rt_data),
        .o_valid (de_valid), .o_pc (de_pc),
        .o_read_data_1 (de_rd1), .o_read_data_2 (de_rd2), .o_addr_ext (de_ext),
        .o_rt (de_rt), .o_rd (de_rd),
        .o_ctrl_wb_bus (de_wb), .o_ctrl_mem_bus (de_m), .o_ctrl_exc_bus (de_ex)
    );

    execute_stage u_execute_stage (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_valid (de_valid), .i_pc (de_pc),
        .i_read_data_1 (de_rd1), .i_read_data_2 (de_rd2), .i_addr_ext (de_ext),
        .i_rt (de_rt), .i_rd (de_rd),
        .i_ctrl_wb_bus (de_wb), .i_ctrl_mem_bus (de_m), .i_ctrl_exc_bus (de_ex),
        .o_valid (em_valid), .o_pc_branch (em_target),
        .o_alu_result (em_result), .o_write_data (em_wdata),
        .o_write_register (em_wreg), .o_alu_zero (em_zero),
        .o_ctrl_wb_bus (em_wb), .o_ctrl_mem_bus (em_m)
    );

    memory_stage u_memory_stage (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_valid (em_valid), .i_pc_branch (em_target),
        .i_alu_result (em_result), .i_write_data (em_wdata),
        .i_write_register (em_wreg), .i_alu_zero (em_zero),
        .i_ctrl_wb_bus (em_wb), .i_ctrl_mem_bus (em_m),
        .o_wb_valid (o_wb_valid), .o_wb_reg (o_wb_reg), .o_wb_data (o_wb_data),
        .o_branch_taken (o_branch_taken), .o_branch_target (o_branch_target)
    );

endmodule

// File: tb/pipeline_assertions.sv
module pipeline_assertions (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_wb_valid,
    input  logic [cpu_pkg::LEN-1:0]  i_wb_data,
    input  logic                     i_branch_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reset edge clears the write-back valid
    wb_idle_after_reset: assert property (@(posedge i_clk) !i_rst |=> !i_wb_valid)
        else $error("o_wb_valid high in the cycle after reset");

    // beq never writes a register
    no_branch_with_write: assert property (@(posedge i_clk) disable iff (!i_rst)
        !(i_branch_taken && i_wb_valid))
        else $error("o_branch_taken and o_wb_valid high together");

    wb_data_known: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_wb_valid |-> !$isunknown(i_wb_data))
        else $error("o_wb_data has unknown bits while o_wb_valid is high");

endmodule

// File: tb/pipeline_tb.sv
module pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int TOTAL_ITEMS  = 5 + 33 + 40 + 48 + 24 + 80;
    // Up to three hazard bubbles per item, three drain steps per test
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * TOTAL_ITEMS + 3 * NUM_TESTS + 3 + 20;

    logic        i_clk, i_rst, i_instr_valid;
    logic [31:0] i_instr, i_pc;
    logic        o_wb_valid, o_branch_taken;
    logic [4:0]  o_wb_reg;
    logic [31:0] o_wb_data, o_branch_target;

    logic [31:0] reg_model [32];
    logic [31:0] mem_model [cpu_pkg::DMEM_DEPTH];
    logic [71:0] expected [$];      // {wb_valid, wb_reg, wb_data, is_beq, taken, target}
    logic [4:0]  recent_dst [$];    // Last three destinations, zero for none
    int          stored_words [$];
    logic [5:0]  functs [5];
    logic [31:0] pc_count;
    int          seed, cycles, errors, mark, tests_passed, tests_failed;

    pipeline_top dut0 (.*);

    bind pipeline_top pipeline_assertions u_pipeline_assertions (
        .i_clk (i_clk), .i_rst (i_rst), .i_wb_valid (o_wb_valid),
        .i_wb_data (o_wb_data), .i_branch_taken (o_branch_taken)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rand_itype(logic [5:0] op);
        return itype_word(op, 5'($urandom), 5'($urandom), 16'($urandom));
    endfunction

    function automatic logic [31:0] rand_rtype();
        return {cpu_pkg::OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom), 5'd0,
                functs[$urandom_range(4, 0)]};
    endfunction

    // Half of the compares use one register for both operands
    function automatic logic [31:0] rand_beq();
        logic [31:0] word;
        word = rand_itype(cpu_pkg::OP_BEQ);
        if ($urandom_range(1, 0) == 1) begin
            word[20:16] = word[25:21];
        end
        return word;
    endfunction

    // Load aimed at a word that was stored earlier
    function automatic logic [31:0] rand_load();
        logic [4:0] rs;
        logic [7:0] low;
        rs  = 5'($urandom);
        low = 8'(stored_words[$urandom_range(stored_words.size() - 1, 0)] * 4)
              - reg_model[rs][7:0];
        return itype_word(cpu_pkg::OP_LW, 5'($urandom), rs, {8'($urandom), low});
    endfunction

    function automatic logic is_busy(logic [4:0] r);
        foreach (recent_dst[n]) begin
            if (r != 5'd0 && recent_dst[n] == r) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report(string name, logic [31:0] got, logic [31:0] want);
        $display("ERR t=%0t %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic check_outputs();
        logic [71:0] e;
        e = expected.pop_front();
        if (o_wb_valid !== e[71]) begin
            report("o_wb_valid", 32'(o_wb_valid), 32'(e[71]));
        end
        if (e[71] && o_wb_reg !== e[70:66]) begin
            report("o_wb_reg", 32'(o_wb_reg), 32'(e[70:66]));
        end
        if (e[71] && o_wb_data !== e[65:34]) begin
            report("o_wb_data", o_wb_data, e[65:34]);
        end
        if (o_branch_taken !== e[32]) begin
            report("o_branch_taken", 32'(o_branch_taken), 32'(e[32]));
        end
        if (e[33] && o_branch_target !== e[31:0]) begin
            report("o_branch_target", o_branch_target, e[31:0]);
        end
    endtask

    // Reference execution at issue time, result due three cycles later
    task automatic expect_item(logic valid, logic [31:0] word, logic [31:0] pc);
        logic [31:0] a, b, imm, sum, res;
        logic [4:0]  dst;
        logic        writes, is_beq;
        a      = reg_model[word[25:21]];
        b      = reg_model[word[20:16]];
        imm    = {{16{word[15]}}, word[15:0]};
        sum    = a + imm;
        dst    = (word[31:26] == cpu_pkg::OP_RTYPE) ? word[15:11] : word[20:16];
        writes = valid && (word[31:26] inside
                           {cpu_pkg::OP_RTYPE, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW});
        is_beq = valid && (word[31:26] == cpu_pkg::OP_BEQ);
        res    = sum;                                   // addi
        if (word[31:26] == cpu_pkg::OP_LW) begin
            res = mem_model[sum[7:2]];
        end else if (word[31:26] == cpu_pkg::OP_RTYPE) begin
            case (word[5:0])
                cpu_pkg::FN_ADD: res = a + b;
                cpu_pkg::FN_SUB: res = a - b;
                cpu_pkg::FN_AND: res = a & b;
                cpu_pkg::FN_OR:  res = a | b;
                default:         res = {31'd0, $signed(a) < $signed(b)};
            endcase
        end
        if (valid && word[31:26] == cpu_pkg::OP_SW) begin
            mem_model[sum[7:2]] = b;
            stored_words.push_back(int'(sum[7:2]));
        end
        if (writes && dst != 5'd0) begin
            reg_model[dst] = res;                       // r0 stays zero
        end
        expected.push_back({writes, dst, res, is_beq, is_beq && (a == b), pc + (imm << 2)});
        recent_dst.push_back(writes ? dst : 5'd0);
        if (recent_dst.size() > 3) begin
            recent_dst.delete(0);
        end
    endtask

    task automatic step(logic valid, logic [31:0] word);
        @(negedge i_clk);
        check_outputs();
        i_instr_valid = valid;
        i_instr       = word;
        i_pc          = pc_count;
        expect_item(valid, word, pc_count);
        pc_count = pc_count + 32'd4;
    endtask

    // Bubbles until no source is written by one of the last three items
    task automatic issue(logic [31:0] word);
        logic uses_rt;
        uses_rt = !(word[31:26] inside {cpu_pkg::OP_ADDI, cpu_pkg::OP_LW});
        while (is_busy(word[25:21]) || (uses_rt && is_busy(word[20:16]))) begin
            step(1'b0, $urandom);
        end
        step(1'b1, word);
    endtask

    task automatic end_test(string name);
        repeat (3) step(1'b0, $urandom);               // Drain the pipe
        if (errors == mark) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, errors - mark);
            tests_failed++;
        end
        mark = errors;
    endtask

    initial begin
        seed          = $urandom(32'h35eb_8c1d);
        i_rst         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_pc          = '0;
        errors        = 0;
        mark          = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        functs        = '{cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND, cpu_pkg::FN_OR,
                          cpu_pkg::FN_SLT};
        reg_model[0]  = '0;
        pc_count      = $urandom & 32'hffff_fffc;
        repeat (3) expect_item(1'b0, '0, '0);          // Pipe empty after reset
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b1;

        repeat (4) step(1'b0, $urandom);
        issue(itype_word(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'($urandom)));
        end_test("outputs idle after reset");

        for (int r = 0; r < 32; r++) begin
            issue(itype_word(cpu_pkg::OP_ADDI, 5'(r), 5'd0, 16'($urandom)));
        end
        issue({cpu_pkg::OP_RTYPE, 15'd0, 5'd0, cpu_pkg::FN_OR});   // Reads r0 back
        end_test("register initialization");

        repeat (40) issue(rand_rtype());
        end_test("random R-type");

        repeat (24) issue(rand_itype(cpu_pkg::OP_SW));
        repeat (24) issue(rand_load());
        end_test("store then load");

        repeat (24) issue(rand_beq());
        end_test("branch compare and target");

        repeat (80) begin
            case ($urandom_range(9, 0))
                0, 1:    step(1'b0, $urandom);
                2, 3, 4: issue(rand_rtype());
                5:       issue(rand_itype(cpu_pkg::OP_ADDI));
                6:       issue(rand_itype(cpu_pkg::OP_SW));
                7:       issue(rand_load());
                default: issue(rand_beq());
            endcase
        end
        end_test("mixed stream with bubbles");

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: sources.f
source/cpu_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/alu_control.sv
source/alu.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline_top.sv
tb/pipeline_assertions.sv
tb/pipeline_tb.sv

// File: Makefile
TOP = pipeline_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
